/* sim.f */
hw/apb_xbar_pkg.sv
hw/apb_slave.sv
hw/apb_cmd_router.sv
hw/apb_master.sv
hw/apb_xbar_1to4.sv
test/tb_apb_xbar.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_apb_xbar
RTL_TOP   := apb_xbar_1to4
FILELIST  := sim.f
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_apb_xbar.sv */
// APB crossbar testbench

`default_nettype none

module tb_apb_xbar;

    import apb_xbar_pkg::*;

    localparam int CLK_PERIOD          = 100;
    localparam int NUM_TRANSFERS       = 400;
    localparam int CYCLES_PER_TRANSFER = 20;

    logic     pclk;
    logic     rst_n;
    apb_req_t up_req;
    apb_rsp_t up_rsp;
    apb_req_t dn_req [NUM_SLAVES];
    apb_rsp_t dn_rsp [NUM_SLAVES] = '{default: '0};

    logic [15:0] lfsr_state = 16'd8281;
    logic [31:0] model_mem  [NUM_SLAVES][64];
    logic [31:0] shadow_mem [NUM_SLAVES][64];
    logic [1:0]  wait_left  [NUM_SLAVES];
    logic [1:0]  wait_cycles;
    apb_req_t    exp_req;
    int          exp_port;

    apb_xbar_1to4 dut_i (
        .pclk   (pclk),
        .rst_n  (rst_n),
        .up_req (up_req),
        .up_rsp (up_rsp),
        .dn_req (dn_req),
        .dn_rsp (dn_rsp)
    );

    initial begin
        pclk = 1'b0;
        forever #(CLK_PERIOD / 2) pclk = ~pclk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Initial memory contents depend on port and word index
    function automatic logic [31:0] fill_word(input int p, input int w);
        return {8'hA0 + 8'(p), 8'(w), 8'(p * 64 + w) ^ 8'h3C, ~8'(w)};
    endfunction

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_rsp(input string name, input apb_resp_t got, input apb_resp_t exp);
        if (got !== exp) begin
            $display("FAILED %s: prdata got %h expected %h, pslverr got %h expected %h",
                     name, got.rdata, exp.rdata, got.slverr, exp.slverr);
            stop_run();
        end
    endtask

    task automatic check_req(input string name, input apb_req_t got, input apb_req_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // Four memory-backed slaves with 0 to 3 wait states and errors at paddr[15:12] == 4'hF
    always @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_SLAVES; p++) begin
                dn_rsp[p]    <= '0;
                wait_left[p] <= '0;
                for (int w = 0; w < 64; w++) begin
                    model_mem[p][w] <= fill_word(p, w);
                end
            end
        end else begin
            for (int p = 0; p < NUM_SLAVES; p++) begin
                dn_rsp[p] <= '0;
                if (dn_req[p].psel && !dn_rsp[p].pready) begin
                    if (!dn_req[p].penable && wait_cycles != 2'd0) begin
                        // Nonzero wait count is loaded in setup and counted down in access
                        wait_left[p] <= wait_cycles - 2'd1;
                    end else if (dn_req[p].penable && wait_left[p] != 2'd0) begin
                        wait_left[p] <= wait_left[p] - 2'd1;
                    end else begin
                        dn_rsp[p].pready <= 1'b1;
                        if (dn_req[p].paddr[15:12] == 4'hF) begin
                            dn_rsp[p].pslverr <= 1'b1;
                        end else if (dn_req[p].pwrite) begin
                            for (int b = 0; b < STRB_WIDTH; b++) begin
                                if (dn_req[p].pstrb[b]) begin
                                    model_mem[p][dn_req[p].paddr[7:2]][8*b +: 8] <=
                                        dn_req[p].pwdata[8*b +: 8];
                                end
                            end
                        end else begin
                            dn_rsp[p].prdata <= model_mem[p][dn_req[p].paddr[7:2]];
                        end
                    end
                end
            end
        end
    end

    // Bus monitor for port selection, forwarded fields and stray pready
    always @(posedge pclk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_SLAVES; p++) begin
                if ((dn_req[p].psel || dn_req[p].penable) && p != exp_port) begin
                    $display("Port %0d raised psel or penable for a transfer not aimed at it",
                             p);
                    stop_run();
                end
                if (dn_req[p].psel && dn_req[p].penable) begin
                    check_req($sformatf("dn_req[%0d]", p), dn_req[p], exp_req);
                end
            end
            if (up_rsp.pready && !(up_req.psel && up_req.penable)) begin
                $display("Upstream pready was raised outside an access phase");
                stop_run();
            end
        end
    end

    task automatic run_transfer();
        logic [31:0] addr;
        logic        write;
        logic        mapped;
        logic        err;
        logic [1:0]  port;
        logic [5:0]  widx;
        apb_req_t    req;
        apb_req_t    acc;
        apb_resp_t   exp_resp;
        apb_resp_t   got_resp;

        // About 70% in the map and the rest fully random
        if (rand_bits(8) < 32'd179) begin
            addr = BASE_ADDR | {14'd0, 2'(rand_bits(2)), 16'(rand_bits(16))};
        end else begin
            addr = rand_bits(32);
        end
        write       = 1'(rand_bits(1));
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.paddr   = addr;
        req.pwrite  = write;
        req.pwdata  = rand_bits(32);
        req.pstrb   = 4'(rand_bits(4));
        req.pprot   = 3'(rand_bits(3));
        acc         = req;
        acc.penable = 1'b1;

        // Reference model
        // The 256 KiB map is aligned, so bits 31:18 alone decide a hit
        mapped = (addr[31:18] == BASE_ADDR[31:18]);
        port   = addr[17:16];
        widx   = addr[7:2];
        err    = !mapped || (addr[15:12] == 4'hF);
        exp_resp.slverr = err;
        exp_resp.rdata  = (err || write) ? '0 : shadow_mem[port][widx];
        if (!err && write) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (req.pstrb[b]) begin
                    shadow_mem[port][widx][8*b +: 8] = req.pwdata[8*b +: 8];
                end
            end
        end

        @(posedge pclk);
        up_req      <= req;
        exp_req     <= acc;
        exp_port    <= mapped ? int'(port) : NUM_SLAVES;
        wait_cycles <= 2'(rand_bits(2));
        @(posedge pclk);
        up_req.penable <= 1'b1;
        @(posedge pclk);
        while (!up_rsp.pready) begin
            @(posedge pclk);
        end
        got_resp.rdata  = up_rsp.prdata;
        got_resp.slverr = up_rsp.pslverr;
        up_req <= '0;
        check_rsp("up_rsp", got_resp, exp_resp);
    endtask

    initial begin
        #((NUM_TRANSFERS * CYCLES_PER_TRANSFER + 20) * CLK_PERIOD);
        $display("Timeout: the transfers did not all complete in time");
        stop_run();
    end

    initial begin
        up_req      = '0;
        rst_n       = 1'b0;
        wait_cycles = '0;
        exp_req     = '0;
        exp_port    = NUM_SLAVES;
        for (int p = 0; p < NUM_SLAVES; p++) begin
            for (int w = 0; w < 64; w++) begin
                shadow_mem[p][w] = fill_word(p, w);
            end
        end
        repeat (5) @(posedge pclk);
        rst_n <= 1'b1;

        // The monitor flags any psel, penable or pready while idle after reset
        repeat (5) @(posedge pclk);

        for (int n = 0; n < NUM_TRANSFERS; n++) begin
            run_transfer();
        end
        repeat (3) @(posedge pclk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/apb_xbar_1to4.sv */
// APB crossbar, one master to four slaves

`default_nettype none

module apb_xbar_1to4 (
    input  wire logic                   pclk,
    input  wire logic                   rst_n,
    input  wire apb_xbar_pkg::apb_req_t up_req,
    output      apb_xbar_pkg::apb_rsp_t up_rsp,
    output      apb_xbar_pkg::apb_req_t dn_req [apb_xbar_pkg::NUM_SLAVES],
    input  wire apb_xbar_pkg::apb_rsp_t dn_rsp [apb_xbar_pkg::NUM_SLAVES]
);

    import apb_xbar_pkg::*;

    // Upstream command and response channels
    logic      up_cmd_valid;
    logic      up_cmd_ready;
    apb_cmd_t  up_cmd;
    logic      up_rsp_valid;
    logic      up_rsp_ready;
    apb_resp_t up_resp;

    // Per-port channels, the command payload is shared
    logic [NUM_SLAVES-1:0] dn_cmd_valid;
    logic [NUM_SLAVES-1:0] dn_cmd_ready;
    apb_cmd_t              dn_cmd;
    logic [NUM_SLAVES-1:0] dn_rsp_valid;
    logic [NUM_SLAVES-1:0] dn_rsp_ready;
    apb_resp_t             dn_resp [NUM_SLAVES];

    apb_slave u_apb_slave (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .apb_req   (up_req),
        .apb_rsp   (up_rsp),
        .cmd_valid (up_cmd_valid),
        .cmd_ready (up_cmd_ready),
        .cmd       (up_cmd),
        .rsp_valid (up_rsp_valid),
        .rsp_ready (up_rsp_ready),
        .rsp       (up_resp)
    );

    apb_cmd_router u_router (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .up_cmd_valid (up_cmd_valid),
        .up_cmd_ready (up_cmd_ready),
        .up_cmd       (up_cmd),
        .up_rsp_valid (up_rsp_valid),
        .up_rsp_ready (up_rsp_ready),
        .up_rsp       (up_resp),
        .dn_cmd_valid (dn_cmd_valid),
        .dn_cmd_ready (dn_cmd_ready),
        .dn_cmd       (dn_cmd),
        .dn_rsp_valid (dn_rsp_valid),
        .dn_rsp_ready (dn_rsp_ready),
        .dn_rsp       (dn_resp)
    );

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_port
        apb_master u_apb_master (
            .pclk      (pclk),
            .rst_n     (rst_n),
            .cmd_valid (dn_cmd_valid[i]),
            .cmd_ready (dn_cmd_ready[i]),
            .cmd       (dn_cmd),
            .rsp_valid (dn_rsp_valid[i]),
            .rsp_ready (dn_rsp_ready[i]),
            .rsp       (dn_resp[i]),
            .apb_req   (dn_req[i]),
            .apb_rsp   (dn_rsp[i])
        );
    end

endmodule

`default_nettype wire

/* hw/apb_master.sv */
// Downstream APB requester
// Replays one command as a setup and access transfer

`default_nettype none

module apb_master (
    input  wire logic                  pclk,
    input  wire logic                  rst_n,
    input  wire logic                  cmd_valid,
    output      logic                  cmd_ready,
    input  wire apb_xbar_pkg::apb_cmd_t  cmd,
    output      logic                  rsp_valid,
    input  wire logic                  rsp_ready,
    output      apb_xbar_pkg::apb_resp_t rsp,
    output      apb_xbar_pkg::apb_req_t  apb_req,
    input  wire apb_xbar_pkg::apb_rsp_t  apb_rsp
);

    import apb_xbar_pkg::*;

    mst_state_e state;
    apb_cmd_t   cmd_q;
    apb_resp_t  rsp_q;

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MST_IDLE;
        end else begin
            case (state)
                MST_IDLE: begin
                    if (cmd_valid) begin
                        state <= MST_SETUP;
                    end
                end
                MST_SETUP: begin
                    state <= MST_ACCESS;
                end
                MST_ACCESS: begin
                    // Wait states last as long as the slave holds pready low
                    if (apb_rsp.pready) begin
                        state <= MST_RSP;
                    end
                end
                MST_RSP: begin
                    if (rsp_ready) begin
                        state <= MST_IDLE;
                    end
                end
                default: begin
                    state <= MST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (state == MST_IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
        if (state == MST_ACCESS && apb_rsp.pready) begin
            rsp_q.rdata  <= apb_rsp.prdata;
            rsp_q.slverr <= apb_rsp.pslverr;
        end
    end

    assign cmd_ready = (state == MST_IDLE);
    assign rsp_valid = (state == MST_RSP);
    assign rsp       = rsp_q;

    // Address and data stay on the latched command through both phases
    assign apb_req.psel    = (state == MST_SETUP) || (state == MST_ACCESS);
    assign apb_req.penable = (state == MST_ACCESS);
    assign apb_req.paddr   = cmd_q.addr;
    assign apb_req.pwrite  = cmd_q.write;
    assign apb_req.pwdata  = cmd_q.wdata;
    assign apb_req.pstrb   = cmd_q.strb;
    assign apb_req.pprot   = cmd_q.prot;

endmodule

`default_nettype wire

/* hw/apb_cmd_router.sv */
// Command router
// Address decode, command steering and response mux

`default_nettype none

module apb_cmd_router (
    input  wire logic                              pclk,
    input  wire logic                              rst_n,
    input  wire logic                              up_cmd_valid,
    output      logic                              up_cmd_ready,
    input  wire apb_xbar_pkg::apb_cmd_t              up_cmd,
    output      logic                              up_rsp_valid,
    input  wire logic                              up_rsp_ready,
    output      apb_xbar_pkg::apb_resp_t             up_rsp,
    output      logic [apb_xbar_pkg::NUM_SLAVES-1:0] dn_cmd_valid,
    input  wire logic [apb_xbar_pkg::NUM_SLAVES-1:0] dn_cmd_ready,
    output      apb_xbar_pkg::apb_cmd_t              dn_cmd,
    input  wire logic [apb_xbar_pkg::NUM_SLAVES-1:0] dn_rsp_valid,
    output      logic [apb_xbar_pkg::NUM_SLAVES-1:0] dn_rsp_ready,
    input  wire apb_xbar_pkg::apb_resp_t             dn_rsp [apb_xbar_pkg::NUM_SLAVES]
);

    import apb_xbar_pkg::*;

    logic                  in_range;
    logic [PORT_WIDTH-1:0] port;
    logic [PORT_WIDTH-1:0] port_q;
    logic                  err_q;

    assign in_range = (up_cmd.addr >= BASE_ADDR) && (up_cmd.addr < (BASE_ADDR + MAP_SIZE));
    assign port     = up_cmd.addr[REGION_BITS +: PORT_WIDTH];

    // Unmapped commands are taken at once and answered locally
    assign up_cmd_ready = up_cmd_valid && (in_range ? dn_cmd_ready[port] : 1'b1);
    assign dn_cmd       = up_cmd;

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            dn_cmd_valid[i] = up_cmd_valid && in_range && (port == PORT_WIDTH'(i));
            dn_rsp_ready[i] = up_rsp_ready && !err_q && (port_q == PORT_WIDTH'(i));
        end
    end

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            port_q <= '0;
            err_q  <= 1'b0;
        end else begin
            if (up_cmd_valid && up_cmd_ready) begin
                port_q <= port;
                err_q  <= !in_range;
            end else if (err_q && up_rsp_ready) begin
                err_q  <= 1'b0;
            end
        end
    end

    // Response comes from the port picked at acceptance
    always_comb begin
        if (err_q) begin
            up_rsp_valid  = 1'b1;
            up_rsp.rdata  = '0;
            up_rsp.slverr = 1'b1;
        end else begin
            up_rsp_valid = dn_rsp_valid[port_q];
            up_rsp       = dn_rsp[port_q];
        end
    end

endmodule

`default_nettype wire

/* hw/apb_slave.sv */
// Upstream APB completer
// Turns one APB transfer into a command and waits for its response

`default_nettype none

module apb_slave (
    input  wire logic                  pclk,
    input  wire logic                  rst_n,
    input  wire apb_xbar_pkg::apb_req_t  apb_req,
    output      apb_xbar_pkg::apb_rsp_t  apb_rsp,
    output      logic                  cmd_valid,
    input  wire logic                  cmd_ready,
    output      apb_xbar_pkg::apb_cmd_t  cmd,
    input  wire logic                  rsp_valid,
    output      logic                  rsp_ready,
    input  wire apb_xbar_pkg::apb_resp_t rsp
);

    import apb_xbar_pkg::*;

    slv_state_e state;
    apb_cmd_t   cmd_q;
    apb_resp_t  rsp_q;

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SLV_IDLE;
        end else begin
            case (state)
                SLV_IDLE: begin
                    // Access phase seen, the bus is held until the response returns
                    if (apb_req.psel && apb_req.penable) begin
                        state <= SLV_CMD;
                    end
                end
                SLV_CMD: begin
                    if (cmd_ready) begin
                        state <= SLV_RSP;
                    end
                end
                SLV_RSP: begin
                    if (rsp_valid) begin
                        state <= SLV_DONE;
                    end
                end
                default: begin
                    state <= SLV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (state == SLV_IDLE && apb_req.psel && apb_req.penable) begin
            cmd_q.write <= apb_req.pwrite;
            cmd_q.addr  <= apb_req.paddr;
            cmd_q.wdata <= apb_req.pwdata;
            cmd_q.strb  <= apb_req.pstrb;
            cmd_q.prot  <= apb_req.pprot;
        end
        if (state == SLV_RSP && rsp_valid) begin
            rsp_q <= rsp;
        end
    end

    assign cmd_valid = (state == SLV_CMD);
    assign cmd       = cmd_q;
    assign rsp_ready = (state == SLV_RSP);

    // Single pready pulse completes the upstream transfer
    assign apb_rsp.pready  = (state == SLV_DONE);
    assign apb_rsp.prdata  = rsp_q.rdata;
    assign apb_rsp.pslverr = rsp_q.slverr;

endmodule

`default_nettype wire

/* hw/apb_xbar_pkg.sv */
// APB crossbar shared types
// Widths, address map and state encodings

`default_nettype none

package apb_xbar_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int PROT_WIDTH = 3;
    localparam int NUM_SLAVES = 4;
    localparam int PORT_WIDTH = $clog2(NUM_SLAVES);

    // Four 64 KiB regions starting at the base
    localparam logic [ADDR_WIDTH-1:0] BASE_ADDR   = 32'h1000_0000;
    localparam int                    REGION_BITS = 16;
    localparam logic [ADDR_WIDTH-1:0] MAP_SIZE    = 32'h0004_0000;

    // Signals driven by the requester side of an APB bus
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic [ADDR_WIDTH-1:0] paddr;
        logic                  pwrite;
        logic [DATA_WIDTH-1:0] pwdata;
        logic [STRB_WIDTH-1:0] pstrb;
        logic [PROT_WIDTH-1:0] pprot;
    } apb_req_t;

    // Signals driven by the completer
    typedef struct packed {
        logic [DATA_WIDTH-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // One transfer on the internal command channel
    typedef struct packed {
        logic                  write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] strb;
        logic [PROT_WIDTH-1:0] prot;
    } apb_cmd_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic                  slverr;
    } apb_resp_t;

    typedef enum logic [1:0] {
        SLV_IDLE,
        SLV_CMD,
        SLV_RSP,
        SLV_DONE
    } slv_state_e;

    typedef enum logic [1:0] {
        MST_IDLE,
        MST_SETUP,
        MST_ACCESS,
        MST_RSP
    } mst_state_e;

endpackage

`default_nettype wire
